// File: logic/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // mips cause register codes.
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_mod  = 5'd1, // store to clean page.
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5
    } exc_code_t;

    // one virtual address, read either by segment or by page.
    typedef union packed {
        struct packed {
            logic [2:0]  seg;
            logic [28:0] rest;
        } seg_view;
        struct packed {
            logic [19:0] vpn;
            logic [11:0] offset;
        } page_view;
    } vaddr_u;

    localparam logic [2:0] seg_kseg0 = 3'd4; // 0x8000_0000.
    localparam logic [2:0] seg_kseg1 = 3'd5; // 0xa000_0000.

endpackage

`default_nettype wire

// File: logic/reset_stretch.sv
`timescale 1ns/1ps
`default_nettype none

module reset_stretch #(
    parameter int RST_HOLD_CYCLES = 16
) (
    input  wire  aclk,
    input  wire  aresetn,
    output logic o_rstn
);

    localparam int CW = $clog2(RST_HOLD_CYCLES + 1);

    logic [CW-1:0] hold_cnt;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold_cnt <= '0;
            o_rstn   <= 1'b0;
        end else if (!o_rstn) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == CW'(RST_HOLD_CYCLES - 1)) begin
                o_rstn <= 1'b1; // release after the last hold edge.
            end
        end
    end

    // once released, only aresetn may pull the core back into reset
    a_no_spurious_reset: assert property (
        @(posedge aclk) aresetn && o_rstn |=> o_rstn
    ) else $error("internal reset dropped while aresetn high");

endmodule

`default_nettype wire

// File: logic/seg_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module seg_mapper (
    input  wire         aclk,
    input  wire         aresetn,
    input  wire         i_req,
    input  wire  [31:0] i_va,
    input  wire         i_kernel_mode,
    input  wire         i_erl,
    input  wire         i_kseg0_cached,
    output logic        o_valid,
    output logic        o_mapped,
    output logic        o_addr_err,
    output logic [31:0] o_unmapped_pa,
    output logic        o_unmapped_cached
);

    mmu_pkg::vaddr_u va;
    logic            mapped;
    logic            addr_err;
    logic [31:0]     unmapped_pa;
    logic            unmapped_cached;

    assign va = i_va;

    always_comb begin
        mapped          = 1'b1;
        addr_err        = 1'b0;
        unmapped_pa     = i_va;
        unmapped_cached = 1'b0;
        if (!i_kernel_mode && va.seg_view.seg[2]) begin
            mapped   = 1'b0; // kernel space from user mode.
            addr_err = 1'b1;
        end else if (va.seg_view.seg == mmu_pkg::seg_kseg0) begin
            mapped          = 1'b0;
            unmapped_pa     = {3'b000, va.seg_view.rest};
            unmapped_cached = i_kseg0_cached;
        end else if (va.seg_view.seg == mmu_pkg::seg_kseg1) begin
            mapped      = 1'b0;
            unmapped_pa = {3'b000, va.seg_view.rest}; // always uncached.
        end else if (!va.seg_view.seg[2] && i_erl) begin
            mapped = 1'b0; // kuseg identity map under erl.
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid    <= 1'b0;
            o_mapped   <= 1'b0;
            o_addr_err <= 1'b0;
        end else begin
            o_valid <= i_req;
            if (i_req) begin
                o_mapped   <= mapped;
                o_addr_err <= addr_err;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (i_req) begin
            o_unmapped_pa     <= unmapped_pa;
            o_unmapped_cached <= unmapped_cached;
        end
    end

    a_mapped_xor_err: assert property (
        @(posedge aclk) !(o_mapped && o_addr_err)
    ) else $error("segment result both mapped and address error");

endmodule

`default_nettype wire

// File: logic/tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup #(
    parameter int TLB_ENTRIES = 8
) (
    input  wire                            aclk,
    input  wire                            aresetn,
    input  wire                            i_req,
    input  wire  [31:0]                    i_va,
    input  wire  [7:0]                     i_asid,
    input  wire                            i_we,
    input  wire  [$clog2(TLB_ENTRIES)-1:0] i_index,
    input  wire  [18:0]                    i_vpn2,
    input  wire  [7:0]                     i_entry_asid,
    input  wire                            i_g,
    input  wire  [19:0]                    i_pfn0,
    input  wire  [19:0]                    i_pfn1,
    input  wire                            i_c0,
    input  wire                            i_c1,
    input  wire                            i_d0,
    input  wire                            i_d1,
    input  wire                            i_v0,
    input  wire                            i_v1,
    output logic                           o_valid,
    output logic                           o_hit,
    output logic [19:0]                    o_pfn,
    output logic                           o_v,
    output logic                           o_d,
    output logic                           o_c
);

    logic [TLB_ENTRIES-1:0] present_q;
    logic [18:0]            vpn2_q [TLB_ENTRIES];
    logic [7:0]             asid_q [TLB_ENTRIES];
    logic                   g_q    [TLB_ENTRIES];
    logic [19:0]            pfn_q  [TLB_ENTRIES][2]; // even, odd.
    logic [1:0]             c_q    [TLB_ENTRIES];
    logic [1:0]             d_q    [TLB_ENTRIES];
    logic [1:0]             v_q    [TLB_ENTRIES];

    mmu_pkg::vaddr_u        va;
    logic                   odd;
    logic [TLB_ENTRIES-1:0] match;
    logic                   hit;
    logic [19:0]            pfn;
    logic                   v;
    logic                   d;
    logic                   c;

    assign va  = i_va;
    assign odd = va.page_view.vpn[0]; // va bit 12.

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            present_q <= '0;
        end else if (i_we) begin
            present_q[i_index] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_we) begin
            vpn2_q[i_index]    <= i_vpn2;
            asid_q[i_index]    <= i_entry_asid;
            g_q[i_index]       <= i_g;
            pfn_q[i_index][0]  <= i_pfn0;
            pfn_q[i_index][1]  <= i_pfn1;
            c_q[i_index]       <= {i_c1, i_c0};
            d_q[i_index]       <= {i_d1, i_d0};
            v_q[i_index]       <= {i_v1, i_v0};
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = present_q[i] && (vpn2_q[i] == va.page_view.vpn[19:1]) &&
                       (g_q[i] || (asid_q[i] == i_asid));
        end
    end

    // one-hot select of the matching half.
    always_comb begin
        hit = 1'b0;
        pfn = '0;
        v   = 1'b0;
        d   = 1'b0;
        c   = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit = 1'b1;
                pfn = pfn_q[i][odd];
                v   = v_q[i][odd];
                d   = d_q[i][odd];
                c   = c_q[i][odd];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
            o_hit   <= 1'b0;
        end else begin
            o_valid <= i_req;
            if (i_req) begin
                o_hit <= hit;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (i_req) begin
            o_pfn <= pfn;
            o_v   <= v;
            o_d   <= d;
            o_c   <= c;
        end
    end

    // software keeps vpn2/asid pairs unique across entries
    a_single_match: assert property (
        @(posedge aclk) disable iff (!aresetn) i_req |-> $onehot0(match)
    ) else $error("multiple tlb entries match one request");

endmodule

`default_nettype wire

// File: logic/xlate_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module xlate_resolve (
    input  wire                    i_seg_valid,
    input  wire                    i_mapped,
    input  wire                    i_addr_err,
    input  wire  [31:0]            i_unmapped_pa,
    input  wire                    i_unmapped_cached,
    input  wire                    i_tlb_hit,
    input  wire  [19:0]            i_pfn,
    input  wire                    i_v,
    input  wire                    i_d,
    input  wire                    i_c,
    input  wire  [11:0]            i_va_lo,
    input  wire                    i_write,
    output logic                   o_valid,
    output logic [31:0]            o_paddr,
    output logic                   o_cached,
    output mmu_pkg::exc_code_t     o_exc
);

    mmu_pkg::vaddr_u    mapped_pa;
    mmu_pkg::exc_code_t exc;

    always_comb begin
        mapped_pa.page_view.vpn    = i_pfn;
        mapped_pa.page_view.offset = i_va_lo;
    end

    always_comb begin
        exc = mmu_pkg::exc_none;
        if (i_addr_err) begin
            exc = i_write ? mmu_pkg::exc_ades : mmu_pkg::exc_adel;
        end else if (i_mapped && (!i_tlb_hit || !i_v)) begin
            exc = i_write ? mmu_pkg::exc_tlbs : mmu_pkg::exc_tlbl; // refill or invalid.
        end else if (i_mapped && i_write && !i_d) begin
            exc = mmu_pkg::exc_mod;
        end
    end

    always_comb begin
        o_valid  = i_seg_valid;
        o_exc    = i_seg_valid ? exc : mmu_pkg::exc_none;
        o_paddr  = '0;
        o_cached = 1'b0;
        if (exc == mmu_pkg::exc_none) begin
            o_paddr  = i_mapped ? mapped_pa : i_unmapped_pa;
            o_cached = i_mapped ? i_c : i_unmapped_cached;
        end
    end

endmodule

`default_nettype wire

// File: logic/mmu_xlate.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_xlate #(
    parameter int TLB_ENTRIES     = 8,
    parameter int RST_HOLD_CYCLES = 16
) (
    input  wire                            aclk,
    input  wire                            aresetn,
    input  wire                            i_va_valid,
    input  wire  [31:0]                    i_va,
    input  wire                            i_write,
    input  wire                            i_kernel_mode,
    input  wire                            i_erl,
    input  wire                            i_kseg0_cached,
    input  wire  [7:0]                     i_asid,
    input  wire                            i_tlb_we,
    input  wire  [$clog2(TLB_ENTRIES)-1:0] i_tlb_index,
    input  wire  [18:0]                    i_tlb_vpn2,
    input  wire  [7:0]                     i_tlb_asid,
    input  wire                            i_tlb_g,
    input  wire  [19:0]                    i_tlb_pfn0,
    input  wire  [19:0]                    i_tlb_pfn1,
    input  wire                            i_tlb_c0,
    input  wire                            i_tlb_c1,
    input  wire                            i_tlb_d0,
    input  wire                            i_tlb_d1,
    input  wire                            i_tlb_v0,
    input  wire                            i_tlb_v1,
    output logic                           o_ready,
    output logic                           o_valid,
    output logic [31:0]                    o_paddr,
    output logic                           o_cached,
    output mmu_pkg::exc_code_t             o_exc
);

    logic        core_rstn;
    logic        req;
    logic        write_q;
    logic [11:0] va_lo_q;
    logic        seg_valid;
    logic        seg_mapped;
    logic        seg_addr_err;
    logic [31:0] seg_unmapped_pa;
    logic        seg_unmapped_cached;
    logic        tlb_valid;
    logic        tlb_hit;
    logic [19:0] tlb_pfn;
    logic        tlb_v;
    logic        tlb_d;
    logic        tlb_c;

    assign o_ready = core_rstn;
    assign req     = i_va_valid && core_rstn; // drop requests until ready.

    always_ff @(posedge aclk) begin
        if (req) begin
            write_q <= i_write;
            va_lo_q <= i_va[11:0];
        end
    end

    reset_stretch #(
        .RST_HOLD_CYCLES(RST_HOLD_CYCLES)
    ) reset_stretch_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .o_rstn  (core_rstn)
    );

    seg_mapper seg_mapper_i (
        .aclk              (aclk),
        .aresetn           (core_rstn),
        .i_req             (req),
        .i_va              (i_va),
        .i_kernel_mode     (i_kernel_mode),
        .i_erl             (i_erl),
        .i_kseg0_cached    (i_kseg0_cached),
        .o_valid           (seg_valid),
        .o_mapped          (seg_mapped),
        .o_addr_err        (seg_addr_err),
        .o_unmapped_pa     (seg_unmapped_pa),
        .o_unmapped_cached (seg_unmapped_cached)
    );

    tlb_lookup #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) tlb_lookup_i (
        .aclk         (aclk),
        .aresetn      (core_rstn),
        .i_req        (req),
        .i_va         (i_va),
        .i_asid       (i_asid),
        .i_we         (i_tlb_we),
        .i_index      (i_tlb_index),
        .i_vpn2       (i_tlb_vpn2),
        .i_entry_asid (i_tlb_asid),
        .i_g          (i_tlb_g),
        .i_pfn0       (i_tlb_pfn0),
        .i_pfn1       (i_tlb_pfn1),
        .i_c0         (i_tlb_c0),
        .i_c1         (i_tlb_c1),
        .i_d0         (i_tlb_d0),
        .i_d1         (i_tlb_d1),
        .i_v0         (i_tlb_v0),
        .i_v1         (i_tlb_v1),
        .o_valid      (tlb_valid),
        .o_hit        (tlb_hit),
        .o_pfn        (tlb_pfn),
        .o_v          (tlb_v),
        .o_d          (tlb_d),
        .o_c          (tlb_c)
    );

    xlate_resolve xlate_resolve_i (
        .i_seg_valid       (seg_valid),
        .i_mapped          (seg_mapped),
        .i_addr_err        (seg_addr_err),
        .i_unmapped_pa     (seg_unmapped_pa),
        .i_unmapped_cached (seg_unmapped_cached),
        .i_tlb_hit         (tlb_hit),
        .i_pfn             (tlb_pfn),
        .i_v               (tlb_v),
        .i_d               (tlb_d),
        .i_c               (tlb_c),
        .i_va_lo           (va_lo_q),
        .i_write           (write_q),
        .o_valid           (o_valid),
        .o_paddr           (o_paddr),
        .o_cached          (o_cached),
        .o_exc             (o_exc)
    );

    // both halves of the lookup must land on the same cycle
    a_results_aligned: assert property (
        @(posedge aclk) seg_valid == tlb_valid
    ) else $error("segment and tlb results out of step");

endmodule

`default_nettype wire

// File: tb/tb_mmu_xlate.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmu_xlate;

    localparam int TLB_ENTRIES     = 8;
    localparam int RST_HOLD_CYCLES = 16;
    localparam int IW              = $clog2(TLB_ENTRIES);
    localparam int N_DIRECTED      = 21; // directed requests.
    localparam int N_RANDOM        = 300;
    localparam int WATCHDOG_NS     = (N_DIRECTED + N_RANDOM + RST_HOLD_CYCLES + 100) * 10;

    logic          aclk = 1'b0;
    logic          aresetn;
    logic          i_va_valid;
    logic [31:0]   i_va;
    logic          i_write;
    logic          i_kernel_mode;
    logic          i_erl;
    logic          i_kseg0_cached;
    logic [7:0]    i_asid;
    logic          i_tlb_we;
    logic [IW-1:0] i_tlb_index;
    logic [18:0]   i_tlb_vpn2;
    logic [7:0]    i_tlb_asid;
    logic          i_tlb_g;
    logic [19:0]   i_tlb_pfn0;
    logic [19:0]   i_tlb_pfn1;
    logic [1:0]    tlb_c;
    logic [1:0]    tlb_d;
    logic [1:0]    tlb_v;
    logic          o_ready;
    logic          o_valid;
    logic [31:0]   o_paddr;
    logic          o_cached;
    mmu_pkg::exc_code_t o_exc;

    // shadow copy of the tlb contents.
    logic          m_present [TLB_ENTRIES];
    logic [18:0]   m_vpn2    [TLB_ENTRIES];
    logic [7:0]    m_asid    [TLB_ENTRIES];
    logic          m_g       [TLB_ENTRIES];
    logic [19:0]   m_pfn0    [TLB_ENTRIES];
    logic [19:0]   m_pfn1    [TLB_ENTRIES];
    logic [1:0]    m_c       [TLB_ENTRIES];
    logic [1:0]    m_d       [TLB_ENTRIES];
    logic [1:0]    m_v       [TLB_ENTRIES];

    logic [37:0]   exp_q [$]; // {exc, cached, paddr}.
    time           sent_q [$]; // issue time of each request.
    logic [31:0]   rng_state = 32'd7;

    always #5 aclk = ~aclk;

    mmu_xlate #(
        .TLB_ENTRIES     (TLB_ENTRIES),
        .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
    ) mmu_xlate_i (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_va_valid     (i_va_valid),
        .i_va           (i_va),
        .i_write        (i_write),
        .i_kernel_mode  (i_kernel_mode),
        .i_erl          (i_erl),
        .i_kseg0_cached (i_kseg0_cached),
        .i_asid         (i_asid),
        .i_tlb_we       (i_tlb_we),
        .i_tlb_index    (i_tlb_index),
        .i_tlb_vpn2     (i_tlb_vpn2),
        .i_tlb_asid     (i_tlb_asid),
        .i_tlb_g        (i_tlb_g),
        .i_tlb_pfn0     (i_tlb_pfn0),
        .i_tlb_pfn1     (i_tlb_pfn1),
        .i_tlb_c0       (tlb_c[0]),
        .i_tlb_c1       (tlb_c[1]),
        .i_tlb_d0       (tlb_d[0]),
        .i_tlb_d1       (tlb_d[1]),
        .i_tlb_v0       (tlb_v[0]),
        .i_tlb_v1       (tlb_v[1]),
        .o_ready        (o_ready),
        .o_valid        (o_valid),
        .o_paddr        (o_paddr),
        .o_cached       (o_cached),
        .o_exc          (o_exc)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [37:0] expect_xlate(input logic [31:0] va, input logic write,
            input logic kernel, input logic erl, input logic k0c, input logic [7:0] asid);
        logic [4:0]  exc;
        logic        cached;
        logic [31:0] pa;
        int          hit_idx;
        logic        odd;
        exc     = mmu_pkg::exc_none;
        cached  = 1'b0;
        pa      = '0;
        hit_idx = -1;
        odd     = va[12];
        if (!kernel && va[31]) begin
            exc = write ? mmu_pkg::exc_ades : mmu_pkg::exc_adel;
        end else if (va[31:29] == mmu_pkg::seg_kseg0) begin
            pa     = {3'b000, va[28:0]};
            cached = k0c;
        end else if (va[31:29] == mmu_pkg::seg_kseg1) begin
            pa = {3'b000, va[28:0]};
        end else if (!va[31] && erl) begin
            pa = va; // identity map.
        end else begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (m_present[i] && m_vpn2[i] == va[31:13] && (m_g[i] || m_asid[i] == asid)) begin
                    hit_idx = i;
                end
            end
            if (hit_idx < 0 || !m_v[hit_idx][odd]) begin
                exc = write ? mmu_pkg::exc_tlbs : mmu_pkg::exc_tlbl;
            end else if (write && !m_d[hit_idx][odd]) begin
                exc = mmu_pkg::exc_mod;
            end else begin
                pa     = {odd ? m_pfn1[hit_idx] : m_pfn0[hit_idx], va[11:0]};
                cached = m_c[hit_idx][odd];
            end
        end
        return {exc, cached, pa};
    endfunction

    function automatic logic [31:0] page_va(input int idx, input logic odd, input logic [11:0] off);
        return {m_vpn2[idx], odd, off};
    endfunction

    task automatic report_error(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "testbench stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] want);
        $display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
        $display("TEST RESULT: FAIL");
        $fatal(1, "testbench stopped on mismatch");
    endtask

    task automatic issue(input logic [31:0] va, input logic write);
        i_va_valid = 1'b1;
        i_va       = va;
        i_write    = write;
        exp_q.push_back(expect_xlate(va, write, i_kernel_mode, i_erl, i_kseg0_cached, i_asid));
        sent_q.push_back($time);
    endtask

    // vpn2 carries the index in its low bits, so entries never overlap.
    task automatic load_entry(input int idx, input int hi, input logic [7:0] asid, input logic g,
            input logic [19:0] pfn0, input logic [19:0] pfn1, input logic [1:0] c,
            input logic [1:0] d, input logic [1:0] v);
        i_tlb_we       = 1'b1;
        i_tlb_index    = IW'(idx);
        i_tlb_vpn2     = 19'((hi << IW) | idx);
        i_tlb_asid     = asid;
        i_tlb_g        = g;
        i_tlb_pfn0     = pfn0;
        i_tlb_pfn1     = pfn1;
        tlb_c          = c;
        tlb_d          = d;
        tlb_v          = v;
        m_present[idx] = 1'b1;
        m_vpn2[idx]    = 19'((hi << IW) | idx);
        m_asid[idx]    = asid;
        m_g[idx]       = g;
        m_pfn0[idx]    = pfn0;
        m_pfn1[idx]    = pfn1;
        m_c[idx]       = c;
        m_d[idx]       = d;
        m_v[idx]       = v;
    endtask

    task automatic next_cycle();
        @(negedge aclk);
        i_va_valid = 1'b0;
        i_tlb_we   = 1'b0;
    endtask

    task automatic req_step(input logic [31:0] va, input logic write);
        issue(va, write);
        next_cycle();
    endtask

    always @(negedge aclk) begin : compare_results
        logic [37:0] want;
        time         sent;
        if (o_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_error("o_valid rose with no request outstanding");
            end else begin
                want = exp_q.pop_front();
                sent = sent_q.pop_front();
                assert ($time - sent == 10)
                    else report_error("result did not arrive one cycle after its request");
                assert (o_exc == want[37:33])
                    else report_mismatch("o_exc", 32'(o_exc), 32'(want[37:33]));
                assert (o_cached == want[32])
                    else report_mismatch("o_cached", 32'(o_cached), 32'(want[32]));
                assert (o_paddr == want[31:0])
                    else report_mismatch("o_paddr", o_paddr, want[31:0]);
            end
        end else if (o_valid === 1'b0) begin
            assert (o_exc == mmu_pkg::exc_none)
                else report_mismatch("o_exc", 32'(o_exc), 32'(mmu_pkg::exc_none));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_error("simulation timed out before all tests finished");
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] rv;
        logic [31:0] pa0;
        logic [31:0] pa1;
        logic [31:0] va;
        int          idx;
        aresetn        = 1'b0;
        i_va_valid     = 1'b0;
        i_va           = '0;
        i_write        = 1'b0;
        i_kernel_mode  = 1'b1;
        i_erl          = 1'b0;
        i_kseg0_cached = 1'b0;
        i_asid         = 8'd1;
        i_tlb_we       = 1'b0;
        i_tlb_index    = '0;
        i_tlb_vpn2     = '0;
        i_tlb_asid     = '0;
        i_tlb_g        = 1'b0;
        i_tlb_pfn0     = '0;
        i_tlb_pfn1     = '0;
        tlb_c          = '0;
        tlb_d          = '0;
        tlb_v          = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m_present[i] = 1'b0;
            m_vpn2[i]    = '0;
        end

        repeat (5) begin
            @(negedge aclk);
            assert (o_ready == 1'b0) else report_mismatch("o_ready", 32'(o_ready), 32'd0);
            assert (o_valid == 1'b0) else report_mismatch("o_valid", 32'(o_valid), 32'd0);
        end
        aresetn    = 1'b1;
        i_va_valid = 1'b1; // must be dropped while not ready.
        i_va       = 32'h8000_0100;
        for (int k = 1; k <= RST_HOLD_CYCLES; k++) begin
            @(negedge aclk);
            assert (o_valid == 1'b0) else report_mismatch("o_valid", 32'(o_valid), 32'd0);
            assert (o_ready == (k == RST_HOLD_CYCLES))
                else report_mismatch("o_ready", 32'(o_ready), 32'(k == RST_HOLD_CYCLES));
        end
        i_va_valid = 1'b0;

        req_step(32'hC000_1000, 1'b0); // empty tlb.
        req_step(32'hE123_4567, 1'b1);

        i_kseg0_cached = 1'b1;
        req_step(32'h8123_4567, 1'b0);
        i_kseg0_cached = 1'b0;
        req_step(32'h9FFF_F000, 1'b1);
        i_kseg0_cached = 1'b1;
        req_step(32'hA000_0010, 1'b0);
        i_erl = 1'b1;
        req_step(32'h1234_5678, 1'b0);
        i_kernel_mode = 1'b0;
        req_step(32'h0000_4000, 1'b1);
        i_erl = 1'b0;

        req_step(32'h8000_0000, 1'b0);
        req_step(32'hC000_0000, 1'b1);
        req_step(32'hA000_1234, 1'b0);

        load_entry(0, 'h0123, 8'd1, 1'b0, 20'h12345, 20'h54321, 2'b01, 2'b11, 2'b11);
        next_cycle();
        load_entry(1, 'hC001, 8'd3, 1'b1, 20'h0AAAA, 20'h0BBBB, 2'b10, 2'b11, 2'b11);
        next_cycle();
        load_entry(2, 'h0456, 8'd1, 1'b0, 20'h00777, 20'h00888, 2'b11, 2'b10, 2'b01);
        next_cycle();
        req_step(page_va(0, 1'b0, 12'h034), 1'b0);
        req_step(page_va(0, 1'b1, 12'hFFC), 1'b1);
        i_kernel_mode = 1'b1;
        req_step(page_va(1, 1'b0, 12'h100), 1'b0);
        req_step(page_va(1, 1'b1, 12'h200), 1'b1);
        i_asid = 8'd2;
        req_step(page_va(1, 1'b0, 12'h300), 1'b0); // global hit.
        i_kernel_mode = 1'b0;
        req_step(page_va(0, 1'b0, 12'h034), 1'b0);
        req_step(page_va(0, 1'b1, 12'h034), 1'b1);

        i_asid = 8'd1;
        req_step(page_va(2, 1'b0, 12'h010), 1'b0);
        req_step(page_va(2, 1'b0, 12'h010), 1'b1); // clean page store.
        req_step(page_va(2, 1'b1, 12'h020), 1'b0);
        req_step(page_va(2, 1'b1, 12'h020), 1'b1);

        for (int n = 0; n < N_RANDOM; n++) begin
            r              = next_rand();
            r2             = next_rand();
            r3             = next_rand();
            rv             = next_rand();
            i_kernel_mode  = r[31] | r[30];
            i_erl          = (r[29:27] == 3'd0);
            i_kseg0_cached = r[26];
            i_asid         = r[25] ? 8'd2 : 8'd1;
            idx            = int'(r[23:16]) % TLB_ENTRIES;
            case (r2[31:29])
                3'd0:    va = {3'b100, rv[28:0]};
                3'd1:    va = {3'b101, rv[28:0]};
                3'd2:    va = rv;
                default: va = {m_vpn2[idx], rv[12:0]};
            endcase
            issue(va, r2[28]);
            if (r3[31:30] == 2'd0) begin
                pa0 = next_rand();
                pa1 = next_rand();
                load_entry(r3[29] ? idx : int'(r3[27:20]) % TLB_ENTRIES, int'(r3[19:4]),
                           r3[3] ? 8'd2 : 8'd1, r3[2:1] == 2'd0, pa0[31:12], pa1[31:12],
                           rv[14:13], {rv[16] | rv[17], rv[18] | rv[19]},
                           {rv[20] | rv[21], rv[22] | rv[23]});
            end
            next_cycle();
        end

        repeat (2) @(negedge aclk);
        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d expected results never arrived", exp_q.size()));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: mmu_xlate.f
logic/mmu_pkg.sv
logic/reset_stretch.sv
logic/seg_mapper.sv
logic/tlb_lookup.sv
logic/xlate_resolve.sv
logic/mmu_xlate.sv
tb/tb_mmu_xlate.sv

// File: Makefile
SRCS := $(shell grep -v '^+' mmu_xlate.f)

.DEFAULT_GOAL := run

obj_dir/Vtb_mmu_xlate: mmu_xlate.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_mmu_xlate -f mmu_xlate.f

run: obj_dir/Vtb_mmu_xlate
	@out="$$(./obj_dir/Vtb_mmu_xlate)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean
